/* source/invaders_video_pkg.sv */
`default_nettype none

package invaders_video_pkg;

	//////////////////////////////
	// Raster types
	//////////////////////////////

	// One screen coordinate, covers 0..1023
	typedef logic [9:0] pix_coord_t;

	// Scan position of the current pixel
	typedef struct packed {
		pix_coord_t x;
		pix_coord_t y;
	} pixel_pos_t;

	// Colour layout [ blue(2) | green(3) | red(3) ]
	typedef logic [7:0] rgb_t;

	// Visible part of the raster
	localparam pix_coord_t H_ACTIVE = 10'd640;
	localparam pix_coord_t V_ACTIVE = 10'd480;

	//////////////////////////////
	// Palette
	//////////////////////////////

	localparam rgb_t COLOR_BLACK     = 8'b00000000;
	localparam rgb_t COLOR_SPACE     = 8'b00000000;
	localparam rgb_t COLOR_GREEN     = 8'b00111000;
	localparam rgb_t COLOR_BLUE      = 8'b11000000;
	localparam rgb_t COLOR_WHITE     = 8'b11111111;
	localparam rgb_t COLOR_SPACESHIP = 8'b01111000;
	localparam rgb_t COLOR_ALIEN     = 8'b10101010;

	// Per-layer hit flags from the object controllers
	typedef struct packed {
		logic ship;
		logic laser;
		logic alien;
	} layer_hits_t;

endpackage

`default_nettype wire

/* source/invaders_game_pkg.sv */
`default_nettype none

package invaders_game_pkg;

	import invaders_video_pkg::*;

	//////////////////////////////
	// Game state types
	//////////////////////////////

	// Screen sequence, advanced by the display button
	typedef enum logic [1:0] {
		MODE_BLANK = 2'd0,
		MODE_START = 2'd1,
		MODE_GAME  = 2'd2
	} screen_mode_t;

	// Sideways march of the alien row
	typedef enum logic {
		DIR_RIGHT = 1'b0,
		DIR_LEFT  = 1'b1
	} march_dir_t;

	// Button levels from the board
	typedef struct packed {
		logic left;
		logic right;
		logic shoot;
		logic display;
	} buttons_t;

	//////////////////////////////
	// Playfield geometry
	//////////////////////////////

	// Horizontal border rows
	localparam pix_coord_t SCOREBOARD_BOTTOM = 10'd60;
	localparam pix_coord_t BARRIER_BOTTOM    = 10'd400;
	localparam pix_coord_t EXTRA_LIVES_TOP   = 10'd445;

	// Start screen frame, inclusive
	localparam pix_coord_t START_FRAME_MIN_X = 10'd10;
	localparam pix_coord_t START_FRAME_MAX_X = 10'd630;
	localparam pix_coord_t START_FRAME_MIN_Y = 10'd10;
	localparam pix_coord_t START_FRAME_MAX_Y = 10'd470;

	// Player ship
	localparam pix_coord_t SHIP_WIDTH   = 10'd40;
	localparam pix_coord_t SHIP_TOP     = 10'd420;
	localparam pix_coord_t SHIP_HEIGHT  = 10'd10;
	localparam pix_coord_t SHIP_START_X = 10'd300;
	localparam pix_coord_t SHIP_MAX_X   = 10'd600;

	// Player laser, spawns just above the ship
	localparam pix_coord_t LASER_WIDTH    = 10'd3;
	localparam pix_coord_t LASER_HEIGHT   = 10'd10;
	localparam pix_coord_t LASER_START_Y  = 10'd410;
	localparam pix_coord_t LASER_X_OFFSET = 10'd18;

	// Alien row
	localparam pix_coord_t ALIEN_WIDTH       = 10'd30;
	localparam pix_coord_t ALIEN_HEIGHT      = 10'd20;
	localparam pix_coord_t ALIEN_PITCH       = 10'd50;
	localparam pix_coord_t FORMATION_START_X = 10'd195;
	localparam pix_coord_t FORMATION_START_Y = 10'd180;
	localparam pix_coord_t ALIEN_DROP        = 10'd10;
	localparam pix_coord_t FORMATION_FLOOR_Y = 10'd300;

endpackage

`default_nettype wire

/* source/screen_mode_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module screen_mode_ctrl (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            display,
	output invaders_game_pkg::screen_mode_t mode,
	output logic                           restart
);

	import invaders_game_pkg::*;

	// Previous button sample
	logic display_prev;
	logic display_rise;
	screen_mode_t mode_next;

	// Press seen when level is high and last sample was low
	assign display_rise = display && !display_prev;

	// Blank -> start -> game -> blank
	always_comb begin
		case (mode)
			MODE_BLANK: mode_next = MODE_START;
			MODE_START: mode_next = MODE_GAME;
			default:    mode_next = MODE_BLANK;
		endcase
	end

	//////////////////////////////
	// Mode and restart registers
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			display_prev <= 1'b0;
			mode         <= MODE_BLANK;
			restart      <= 1'b0;
		end else begin
			display_prev <= display;
			// Restart follows every mode change by one cycle
			restart      <= display_rise;
			if (display_rise) begin
				mode <= mode_next;
			end
		end
	end

endmodule

`default_nettype wire

/* source/spaceship_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module spaceship_ctrl #(
	parameter invaders_video_pkg::pix_coord_t SHIP_STEP  = 10'd4,
	parameter invaders_video_pkg::pix_coord_t LASER_STEP = 10'd8
) (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            restart,
	input  wire                            frame_tick,
	input  invaders_game_pkg::screen_mode_t mode,
	input  invaders_game_pkg::buttons_t    buttons,
	input  invaders_video_pkg::pixel_pos_t pixel,
	output logic                           ship_hit,
	output logic                           laser_hit
);

	import invaders_video_pkg::*;
	import invaders_game_pkg::*;

	// Ship left edge
	pix_coord_t ship_x;
	pix_coord_t ship_x_next;

	// Laser shot, position is its top left corner
	logic       laser_active;
	pix_coord_t laser_x;
	pix_coord_t laser_y;

	logic game_tick;

	// Objects only move on a frame tick in game mode
	assign game_tick = frame_tick && (mode == MODE_GAME);

	//////////////////////////////
	// Ship movement
	//////////////////////////////

	// Single button moves, both or none hold still
	always_comb begin
		ship_x_next = ship_x;
		if (buttons.left && !buttons.right) begin
			// Floor at column 0
			if (ship_x < SHIP_STEP) begin
				ship_x_next = '0;
			end else begin
				ship_x_next = ship_x - SHIP_STEP;
			end
		end else if (buttons.right && !buttons.left) begin
			// Cap at right limit
			if (ship_x > SHIP_MAX_X - SHIP_STEP) begin
				ship_x_next = SHIP_MAX_X;
			end else begin
				ship_x_next = ship_x + SHIP_STEP;
			end
		end
	end

	//////////////////////////////
	// Ship and laser state
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ship_x       <= SHIP_START_X;
			laser_active <= 1'b0;
			laser_x      <= '0;
			laser_y      <= LASER_START_Y;
		end else if (restart) begin
			// Back to start positions, shot cleared
			ship_x       <= SHIP_START_X;
			laser_active <= 1'b0;
			laser_x      <= '0;
			laser_y      <= LASER_START_Y;
		end else if (game_tick) begin
			ship_x <= ship_x_next;
			if (laser_active) begin
				// Top would pass the scoreboard border
				if (laser_y < SCOREBOARD_BOTTOM + LASER_STEP) begin
					laser_active <= 1'b0;
				end else begin
					laser_y <= laser_y - LASER_STEP;
				end
			end else if (buttons.shoot) begin
				// Spawn from the ship position before this tick
				laser_active <= 1'b1;
				laser_x      <= ship_x + LASER_X_OFFSET;
				laser_y      <= LASER_START_Y;
			end
		end
	end

	//////////////////////////////
	// Pixel hit tests
	//////////////////////////////

	assign ship_hit = (pixel.x >= ship_x) && (pixel.x < ship_x + SHIP_WIDTH) &&
		(pixel.y >= SHIP_TOP) && (pixel.y < SHIP_TOP + SHIP_HEIGHT);

	// Inactive shot is invisible
	assign laser_hit = laser_active &&
		(pixel.x >= laser_x) && (pixel.x < laser_x + LASER_WIDTH) &&
		(pixel.y >= laser_y) && (pixel.y < laser_y + LASER_HEIGHT);

endmodule

`default_nettype wire

/* source/alien_formation.sv */
`timescale 1ns/1ps
`default_nettype none

module alien_formation #(
	parameter invaders_video_pkg::pix_coord_t ALIEN_STEP  = 10'd2,
	parameter int unsigned                    ALIEN_COUNT = 6
) (
	input  wire                            clk,
	input  wire                            rst,
	input  wire                            restart,
	input  wire                            frame_tick,
	input  invaders_game_pkg::screen_mode_t mode,
	input  invaders_video_pkg::pixel_pos_t pixel,
	output logic                           alien_hit
);

	import invaders_video_pkg::*;
	import invaders_game_pkg::*;

	// Left edge of first alien to right edge of last
	localparam pix_coord_t ROW_SPAN = pix_coord_t'(ALIEN_PITCH * (ALIEN_COUNT - 1) + ALIEN_WIDTH);

	// Shared origin of the whole row
	pix_coord_t origin_x;
	pix_coord_t origin_y;
	march_dir_t dir;

	logic        game_tick;
	logic [10:0] right_reach;
	logic        at_right_edge;
	logic        at_left_edge;
	logic        at_edge;
	logic        row_hit;
	logic [ALIEN_COUNT-1:0] slot_hit;

	assign game_tick = frame_tick && (mode == MODE_GAME);

	//////////////////////////////
	// Edge detection
	//////////////////////////////

	// Right side of the row after one more step, one bit wider
	assign right_reach   = {1'b0, origin_x} + {1'b0, ROW_SPAN} + {1'b0, ALIEN_STEP};
	assign at_right_edge = (dir == DIR_RIGHT) && (right_reach > {1'b0, H_ACTIVE});
	assign at_left_edge  = (dir == DIR_LEFT) && (origin_x < ALIEN_STEP);
	assign at_edge       = at_right_edge || at_left_edge;

	//////////////////////////////
	// March state
	//////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			origin_x <= FORMATION_START_X;
			origin_y <= FORMATION_START_Y;
			dir      <= DIR_RIGHT;
		end else if (restart) begin
			origin_x <= FORMATION_START_X;
			origin_y <= FORMATION_START_Y;
			dir      <= DIR_RIGHT;
		end else if (game_tick) begin
			if (at_edge) begin
				// Reverse, drop unless already on the floor
				dir <= (dir == DIR_RIGHT) ? DIR_LEFT : DIR_RIGHT;
				if (origin_y < FORMATION_FLOOR_Y) begin
					origin_y <= origin_y + ALIEN_DROP;
				end
			end else if (dir == DIR_RIGHT) begin
				origin_x <= origin_x + ALIEN_STEP;
			end else begin
				origin_x <= origin_x - ALIEN_STEP;
			end
		end
	end

	//////////////////////////////
	// Pixel hit test
	//////////////////////////////

	// All aliens share the same rows
	assign row_hit = (pixel.y >= origin_y) && (pixel.y < origin_y + ALIEN_HEIGHT);

	// One column window per slot
	for (genvar g = 0; g < ALIEN_COUNT; g++) begin : g_slot
		localparam pix_coord_t SLOT_OFFSET = pix_coord_t'(g * ALIEN_PITCH);
		pix_coord_t slot_x;

		assign slot_x      = origin_x + SLOT_OFFSET;
		assign slot_hit[g] = (pixel.x >= slot_x) && (pixel.x < slot_x + ALIEN_WIDTH);
	end

	assign alien_hit = row_hit && (|slot_hit);

endmodule

`default_nettype wire

/* source/pixel_mixer.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer (
	input  wire                             clk,
	input  wire                             rst,
	input  invaders_game_pkg::screen_mode_t mode,
	input  invaders_video_pkg::pixel_pos_t  pixel,
	input  invaders_video_pkg::layer_hits_t hits,
	output invaders_video_pkg::rgb_t        rgb
);

	import invaders_video_pkg::*;
	import invaders_game_pkg::*;

	logic in_active;
	logic in_frame;
	rgb_t color_next;

	assign in_active = (pixel.x < H_ACTIVE) && (pixel.y < V_ACTIVE);

	// Start screen frame, edges included
	assign in_frame = (pixel.x >= START_FRAME_MIN_X) && (pixel.x <= START_FRAME_MAX_X) &&
		(pixel.y >= START_FRAME_MIN_Y) && (pixel.y <= START_FRAME_MAX_Y);

	//////////////////////////////
	// Colour select
	//////////////////////////////

	always_comb begin
		color_next = COLOR_BLACK;
		if (in_active) begin
			case (mode)
				MODE_START: begin
					if (in_frame) begin
						color_next = COLOR_GREEN;
					end
				end
				MODE_GAME: begin
					// Borders first, then ship, laser, aliens
					if (pixel.y == SCOREBOARD_BOTTOM) begin
						color_next = COLOR_GREEN;
					end else if (pixel.y == BARRIER_BOTTOM) begin
						color_next = COLOR_BLUE;
					end else if (pixel.y == EXTRA_LIVES_TOP) begin
						color_next = COLOR_GREEN;
					end else if (hits.ship) begin
						color_next = COLOR_SPACESHIP;
					end else if (hits.laser) begin
						color_next = COLOR_WHITE;
					end else if (hits.alien) begin
						color_next = COLOR_ALIEN;
					end else begin
						color_next = COLOR_SPACE;
					end
				end
				// Blank screen
				default: color_next = COLOR_BLACK;
			endcase
		end
	end

	// One cycle pixel to colour
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= COLOR_BLACK;
		end else begin
			rgb <= color_next;
		end
	end

endmodule

`default_nettype wire

/* source/invaders_top.sv */
`timescale 1ns/1ps
`default_nettype none

module invaders_top #(
	parameter invaders_video_pkg::pix_coord_t SHIP_STEP   = 10'd4,
	parameter invaders_video_pkg::pix_coord_t LASER_STEP  = 10'd8,
	parameter invaders_video_pkg::pix_coord_t ALIEN_STEP  = 10'd2,
	parameter int unsigned                    ALIEN_COUNT = 6
) (
	input  wire                            clk,
	input  wire                            rst,
	input  invaders_game_pkg::buttons_t    buttons,
	input  wire                            frame_tick,
	input  invaders_video_pkg::pixel_pos_t pixel,
	output invaders_video_pkg::rgb_t       rgb
);

	import invaders_video_pkg::*;
	import invaders_game_pkg::*;

	screen_mode_t mode;
	logic         restart;
	// Ship and laser flags from one controller, aliens from the other
	layer_hits_t  hits;

	//////////////////////////////
	// Mode control
	//////////////////////////////

	screen_mode_ctrl i_screen_mode_ctrl (
		.clk     (clk),
		.rst     (rst),
		.display (buttons.display),
		.mode    (mode),
		.restart (restart)
	);

	//////////////////////////////
	// Game objects
	//////////////////////////////

	spaceship_ctrl #(
		.SHIP_STEP  (SHIP_STEP),
		.LASER_STEP (LASER_STEP)
	) i_spaceship_ctrl (
		.clk        (clk),
		.rst        (rst),
		.restart    (restart),
		.frame_tick (frame_tick),
		.mode       (mode),
		.buttons    (buttons),
		.pixel      (pixel),
		.ship_hit   (hits.ship),
		.laser_hit  (hits.laser)
	);

	alien_formation #(
		.ALIEN_STEP  (ALIEN_STEP),
		.ALIEN_COUNT (ALIEN_COUNT)
	) i_alien_formation (
		.clk        (clk),
		.rst        (rst),
		.restart    (restart),
		.frame_tick (frame_tick),
		.mode       (mode),
		.pixel      (pixel),
		.alien_hit  (hits.alien)
	);

	// Registered colour output
	pixel_mixer i_pixel_mixer (
		.clk   (clk),
		.rst   (rst),
		.mode  (mode),
		.pixel (pixel),
		.hits  (hits),
		.rgb   (rgb)
	);

endmodule

`default_nettype wire

/* bench/invaders_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module invaders_tb;

	import invaders_video_pkg::*;
	import invaders_game_pkg::*;

	// Step sizes handed to the DUT
	localparam int SHIP_STEP   = 4;
	localparam int LASER_STEP  = 8;
	localparam int ALIEN_STEP  = 2;
	localparam int ALIEN_COUNT = 6;

	// One frame is a tick cycle and then sample cycles
	localparam int FIXED_SAMPLES  = 8;
	localparam int RANDOM_SAMPLES = 8;
	localparam int FRAME_CYCLES   = 1 + FIXED_SAMPLES + RANDOM_SAMPLES;

	localparam int START_TICKS     = 3;
	localparam int OVERLAP_TICKS   = 61;
	localparam int LEFT_TICKS      = 80;
	localparam int RIGHT_TICKS     = 160;
	localparam int BOTH_TICKS      = 10;
	localparam int LASER_TICKS     = 60;
	localparam int MARCH_TICKS     = 200;
	localparam int EXIT_SHOT_TICKS = 1;
	localparam int FREEZE_TICKS    = 10;
	localparam int TOTAL_TICKS     = START_TICKS + OVERLAP_TICKS + LEFT_TICKS + RIGHT_TICKS +
		BOTH_TICKS + LASER_TICKS + MARCH_TICKS + EXIT_SHOT_TICKS + FREEZE_TICKS;
	// Scene checks and button presses fit in the margin
	localparam int WATCHDOG_NS = TOTAL_TICKS * FRAME_CYCLES * 100 + 100000;

	logic       clk;
	logic       rst;
	buttons_t   buttons;
	logic       frame_tick;
	pixel_pos_t pixel;
	rgb_t       rgb;

	// Reference state of mode and objects
	screen_mode_t model_mode;
	int           model_ship_x;
	logic         model_laser_on;
	int           model_laser_x;
	int           model_laser_y;
	int           model_org_x;
	int           model_org_y;
	march_dir_t   model_dir;

	// Pending checks, one per driven pixel
	rgb_t        exp_q[$];
	string       name_q[$];
	int          due_q[$];
	int          cycle = 0;
	logic [31:0] rng_state;

	// Shot position at the moment the game is left
	int          stale_shot_x;
	int          stale_shot_y;

	invaders_top #(
		.SHIP_STEP   (pix_coord_t'(SHIP_STEP)),
		.LASER_STEP  (pix_coord_t'(LASER_STEP)),
		.ALIEN_STEP  (pix_coord_t'(ALIEN_STEP)),
		.ALIEN_COUNT (ALIEN_COUNT)
	) i_invaders_top (
		.clk        (clk),
		.rst        (rst),
		.buttons    (buttons),
		.frame_tick (frame_tick),
		.pixel      (pixel),
		.rgb        (rgb)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Any of the aliens covers this pixel
	function automatic bit alien_at(input int x, input int y);
		bit hit;
		hit = 1'b0;
		if (y >= model_org_y && y <= model_org_y + 19) begin
			for (int i = 0; i < ALIEN_COUNT; i++) begin
				if (x >= model_org_x + 50 * i && x <= model_org_x + 50 * i + 29) begin
					hit = 1'b1;
				end
			end
		end
		return hit;
	endfunction

	function automatic rgb_t expected_rgb(input int x, input int y);
		rgb_t color;
		bit   ship;
		bit   laser;
		ship = (x >= model_ship_x) && (x <= model_ship_x + 39) && (y >= 420) && (y <= 429);
		laser = model_laser_on && (x >= model_laser_x) && (x <= model_laser_x + 2) &&
			(y >= model_laser_y) && (y <= model_laser_y + 9);
		color = COLOR_BLACK;
		if (x < 640 && y < 480) begin
			if (model_mode == MODE_START) begin
				if (x >= 10 && x <= 630 && y >= 10 && y <= 470) begin
					color = COLOR_GREEN;
				end
			end else if (model_mode == MODE_GAME) begin
				// Borders, ship, laser, aliens, then empty space
				if (y == 60) color = COLOR_GREEN;
				else if (y == 400) color = COLOR_BLUE;
				else if (y == 445) color = COLOR_GREEN;
				else if (ship) color = COLOR_SPACESHIP;
				else if (laser) color = COLOR_WHITE;
				else if (alien_at(x, y)) color = COLOR_ALIEN;
				else color = COLOR_SPACE;
			end
		end
		return color;
	endfunction

	task automatic reset_model();
		model_ship_x   = 300;
		model_laser_on = 1'b0;
		model_laser_x  = 0;
		model_laser_y  = 410;
		model_org_x    = 195;
		model_org_y    = 180;
		model_dir      = DIR_RIGHT;
	endtask

	// One game tick, decided from the state before it
	task automatic advance_model();
		int  old_ship;
		bit  edge_hit;
		old_ship = model_ship_x;
		if (model_mode == MODE_GAME) begin
			if (buttons.left && !buttons.right) begin
				model_ship_x = (model_ship_x < SHIP_STEP) ? 0 : model_ship_x - SHIP_STEP;
			end else if (buttons.right && !buttons.left) begin
				model_ship_x = (model_ship_x + SHIP_STEP > 600) ? 600 : model_ship_x + SHIP_STEP;
			end
			if (model_laser_on) begin
				if (model_laser_y - LASER_STEP < 60) model_laser_on = 1'b0;
				else model_laser_y = model_laser_y - LASER_STEP;
			end else if (buttons.shoot) begin
				model_laser_on = 1'b1;
				model_laser_x  = old_ship + 18;
				model_laser_y  = 410;
			end
			// Edge test from the span of the whole row
			if (model_dir == DIR_RIGHT) begin
				edge_hit = model_org_x + 50 * (ALIEN_COUNT - 1) + 30 + ALIEN_STEP > 640;
			end else begin
				edge_hit = model_org_x < ALIEN_STEP;
			end
			if (edge_hit) begin
				model_dir = (model_dir == DIR_RIGHT) ? DIR_LEFT : DIR_RIGHT;
				if (model_org_y < 300) model_org_y = model_org_y + 10;
			end else if (model_dir == DIR_RIGHT) begin
				model_org_x = model_org_x + ALIEN_STEP;
			end else begin
				model_org_x = model_org_x - ALIEN_STEP;
			end
		end
	endtask

	//////////////////////////////
	// Checks and stimulus
	//////////////////////////////

	task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
		if (actual !== expected) begin
			$display("CHECK FAILED %s expected %b actual %b", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1, "rgb mismatch");
		end
	endtask

	// Colour of a pixel is due on the cycle after it is sampled
	always @(negedge clk) begin
		while (due_q.size() > 0 && due_q[0] == cycle) begin
			check_rgb(name_q[0], exp_q[0], rgb);
			due_q.delete(0);
			name_q.delete(0);
			exp_q.delete(0);
		end
	end

	task automatic drive_cycle(input string name, input int x, input int y,
		input logic tick, input logic press);
		@(posedge clk);
		#5;
		frame_tick      = tick;
		buttons.display = press;
		pixel.x         = pix_coord_t'(x);
		pixel.y         = pix_coord_t'(y);
		exp_q.push_back(expected_rgb(x, y));
		name_q.push_back(name);
		due_q.push_back(cycle + 1);
	endtask

	task automatic sample(input string name, input int x, input int y);
		drive_cycle(name, x, y, 1'b0, 1'b0);
	endtask

	task automatic random_samples(input string name, input int count);
		int x;
		int y;
		for (int i = 0; i < count; i++) begin
			rng_state = xorshift32(rng_state);
			// Range reaches a little past the active area
			x = rng_state[15:0] % 700;
			y = rng_state[31:16] % 520;
			sample(name, x, y);
		end
	endtask

	// Fixed points on object edges
	task automatic object_samples(input string name);
		sample({name, " ship corner"}, model_ship_x, 420);
		sample({name, " right of ship"}, model_ship_x + 40, 425);
		sample({name, " laser top"}, model_laser_x, model_laser_y);
		sample({name, " laser bottom"}, model_laser_x + 2, model_laser_y + 9);
		sample({name, " right of laser"}, model_laser_x + 3, model_laser_y);
		sample({name, " first alien"}, model_org_x, model_org_y);
		sample({name, " last alien"}, model_org_x + 279, model_org_y + 19);
		sample({name, " alien gap"}, model_org_x + 30, model_org_y + 10);
	endtask

	task automatic game_frame(input string name);
		// Tick pixel sits off screen
		drive_cycle({name, " tick"}, 700, 100, 1'b1, 1'b0);
		advance_model();
		object_samples(name);
		random_samples({name, " random"}, RANDOM_SAMPLES);
	endtask

	task automatic press_display();
		drive_cycle("display press", 700, 100, 1'b0, 1'b1);
		drive_cycle("display release", 700, 100, 1'b0, 1'b0);
		drive_cycle("restart settle", 700, 100, 1'b0, 1'b0);
		case (model_mode)
			MODE_BLANK: model_mode = MODE_START;
			MODE_START: model_mode = MODE_GAME;
			default:    model_mode = MODE_BLANK;
		endcase
		reset_model();
	endtask

	task automatic start_scene(input string name);
		sample({name, " border 60"}, 100, 60);
		sample({name, " border 400"}, 320, 400);
		sample({name, " border 445"}, 500, 445);
		sample({name, " ship left"}, 300, 420);
		sample({name, " ship right"}, 339, 429);
		sample({name, " left of ship"}, 299, 425);
		sample({name, " laser spawn spot"}, 318, 410);
		for (int i = 0; i < ALIEN_COUNT; i++) begin
			sample({name, " alien top left"}, 195 + 50 * i, 180);
			sample({name, " alien bottom right"}, 224 + 50 * i, 199);
			sample({name, " above alien"}, 195 + 50 * i, 179);
			sample({name, " between aliens"}, 225 + 50 * i, 190);
		end
		sample({name, " outside right"}, 640, 100);
		sample({name, " outside bottom"}, 100, 480);
		sample({name, " far outside"}, 1000, 1000);
	endtask

	// Fire from the start position until the shot crosses the row
	task automatic laser_over_alien();
		int guard;
		int y;
		buttons.shoot = 1'b1;
		game_frame("laser fire");
		buttons.shoot = 1'b0;
		guard = 0;
		while (!(model_laser_y <= model_org_y + 19 && model_laser_y + 9 >= model_org_y) &&
			guard < OVERLAP_TICKS - 1) begin
			game_frame("laser climb");
			guard++;
		end
		y = (model_laser_y > model_org_y) ? model_laser_y : model_org_y;
		if (!model_laser_on || !alien_at(model_laser_x + 1, y)) begin
			$display("Laser shot never crossed an alien, overlap could not be checked");
			$display("TESTS FAILED");
			$fatal(1, "no overlap");
		end
		sample("laser over alien", model_laser_x + 1, y);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		buttons    = '0;
		frame_tick = 1'b0;
		pixel      = '0;
		rng_state  = 32'd43;
		model_mode = MODE_BLANK;
		reset_model();
		repeat (5) @(posedge clk);
		#5;
		rst = 1'b0;

		// Blank after reset, then start frame
		random_samples("blank after reset", 16);
		sample("blank centre", 320, 240);
		press_display();
		sample("start centre", 320, 240);
		sample("start frame corner", 10, 10);
		sample("start outside frame", 5, 5);
		sample("start outside far corner", 635, 475);
		sample("start frame far corner", 630, 470);
		random_samples("start random", 16);
		for (int i = 0; i < START_TICKS; i++) game_frame("start mode tick");

		// Game scene and priority
		press_display();
		start_scene("game start");
		laser_over_alien();

		// Both buttons away from the limits, then clamping at both sides
		buttons.left  = 1'b1;
		buttons.right = 1'b1;
		for (int i = 0; i < BOTH_TICKS; i++) game_frame("ship both buttons");
		buttons.right = 1'b0;
		for (int i = 0; i < LEFT_TICKS; i++) game_frame("ship left");
		buttons.left  = 1'b0;
		buttons.right = 1'b1;
		for (int i = 0; i < RIGHT_TICKS; i++) game_frame("ship right");
		buttons.right = 1'b0;

		// Shoot held through a whole flight and a respawn
		buttons.shoot = 1'b1;
		for (int i = 0; i < LASER_TICKS; i++) game_frame("laser held");
		buttons.shoot = 1'b0;

		for (int i = 0; i < MARCH_TICKS; i++) game_frame("formation march");

		// Shot still in flight when the game is left
		buttons.shoot = 1'b1;
		game_frame("shot before blank");
		buttons.shoot = 1'b0;
		stale_shot_x = model_laser_x;
		stale_shot_y = model_laser_y;

		// Blank screen freezes, two presses bring a fresh game
		press_display();
		buttons.left = 1'b1;
		for (int i = 0; i < FREEZE_TICKS; i++) game_frame("frozen blank");
		buttons.left = 1'b0;
		press_display();
		press_display();
		start_scene("game restart");
		sample("old shot cleared", stale_shot_x + 1, stale_shot_y);

		repeat (3) @(posedge clk);
		if (due_q.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("TESTS FAILED");
			$fatal(1, "checks left unresolved");
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the test sequence finished");
		$display("TESTS FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* sim.f */
source/invaders_video_pkg.sv
source/invaders_game_pkg.sv
source/screen_mode_ctrl.sv
source/spaceship_ctrl.sv
source/alien_formation.sv
source/pixel_mixer.sv
source/invaders_top.sv
bench/invaders_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module invaders_tb -f sim.f -o invaders_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/invaders_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Result comes from the log
if grep -q "^TESTS PASSED$" "$LOG"; then
	exit 0
fi
exit 1
